// File: ddr_tg_params.svh
// DDR4 traffic checker sizing macros shared by RTL and testbench
`ifndef DDR_TG_PARAMS_SVH
`define DDR_TG_PARAMS_SVH

// Lane split of the application data word
`define DDR_TG_NUM_LANES 4
`define DDR_TG_LANE_W    32
`define DDR_TG_DATA_W    (`DDR_TG_NUM_LANES * `DDR_TG_LANE_W)

// Beat counters and bus widths
`define DDR_TG_BEAT_W    16
`define DDR_TG_APB_AW    8
`define DDR_TG_APP_AW    28

`endif

// File: ddr_tg_reg_pkg.sv
// DDR4 traffic checker register map offsets and status record
`default_nettype none
`include "ddr_tg_params.svh"

package ddr_tg_reg_pkg;

  // APB register offsets
  localparam logic [`DDR_TG_APB_AW-1:0] REG_CTRL      = 'h00;
  localparam logic [`DDR_TG_APB_AW-1:0] REG_BEATS     = 'h04;
  localparam logic [`DDR_TG_APB_AW-1:0] REG_SEED      = 'h08;
  localparam logic [`DDR_TG_APB_AW-1:0] REG_STATUS    = 'h0C;
  localparam logic [`DDR_TG_APB_AW-1:0] REG_ERR_COUNT = 'h10;
  localparam logic [`DDR_TG_APB_AW-1:0] REG_LANE_MASK = 'h14;

  // Run result as seen by software
  typedef struct packed {
    logic                         done;
    logic                         error;
    logic [`DDR_TG_BEAT_W-1:0]    err_count;
    logic [`DDR_TG_NUM_LANES-1:0] lane_mask;
  } status_t;

endpackage

`default_nettype wire

// File: ddr_tg_data_pkg.sv
// DDR4 traffic checker data path types for lanes and sequencer
`default_nettype none
`include "ddr_tg_params.svh"

package ddr_tg_data_pkg;

  // One lane slice of the application word
  typedef logic [`DDR_TG_LANE_W-1:0] lane_word_t;

  // Sequencer phases
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    WRITE     = 2'd1,
    READ      = 2'd2,
    WAIT_DONE = 2'd3
  } phase_e;

endpackage

`default_nettype wire

// File: ddr_tg_if.sv
// DDR4 traffic checker control and lane result interfaces
`timescale 1ns/1ns
`default_nettype none
`include "ddr_tg_params.svh"

// Broadcast from the sequencer to every lane and to the collector
interface lane_ctrl_if;
  logic                            start;
  ddr_tg_data_pkg::lane_word_t     seed;
  logic [`DDR_TG_BEAT_W-1:0]       beats;
  logic                            wr_fire;
  logic                            rd_valid;
  logic [`DDR_TG_DATA_W-1:0]       rd_data;

  modport sequencer (
    output start, seed, beats, wr_fire, rd_valid, rd_data
  );

  modport lane (
    input start, seed, wr_fire, rd_valid, rd_data
  );

  // Collector only needs run boundaries and the beat target
  modport monitor (
    input start, beats
  );
endinterface

// One per lane
interface lane_result_if;
  ddr_tg_data_pkg::lane_word_t wr_word;
  logic                        mismatch;
  logic                        mismatch_valid;

  modport lane (
    output wr_word, mismatch, mismatch_valid
  );

  modport sequencer (
    input wr_word
  );

  modport collector (
    input mismatch, mismatch_valid
  );
endinterface

`default_nettype wire

// File: ddr_tg_sequencer.sv
// DDR4 traffic checker APB register block and application port command sequencer
`timescale 1ns/1ns
`default_nettype none
`include "ddr_tg_params.svh"

module ddr_tg_sequencer (
  input  wire                          c0_ddr4_clk,
  input  wire                          arst_n_i,
  // APB slave
  input  wire                          psel_i,
  input  wire                          penable_i,
  input  wire                          pwrite_i,
  input  wire [`DDR_TG_APB_AW-1:0]     paddr_i,
  input  wire [31:0]                   pwdata_i,
  output logic [31:0]                  prdata_o,
  output logic                         pslverr_o,
  // Controller side
  input  wire                          init_calib_complete_i,
  input  wire                          app_rdy_i,
  input  wire                          app_wdf_rdy_i,
  input  wire [`DDR_TG_DATA_W-1:0]     app_rd_data_i,
  input  wire                          app_rd_data_valid_i,
  output logic                         app_en_o,
  output logic [2:0]                   app_cmd_o,
  output logic [`DDR_TG_APP_AW-1:0]    app_addr_o,
  output logic [`DDR_TG_DATA_W-1:0]    app_wdf_data_o,
  output logic                         app_wdf_wren_o,
  output logic                         app_wdf_end_o,
  // Status from the collector
  input  wire ddr_tg_reg_pkg::status_t status_i,
  output logic                         clr_o,
  lane_ctrl_if.sequencer               ctrl,
  lane_result_if.sequencer             res [`DDR_TG_NUM_LANES]
);

  ddr_tg_data_pkg::phase_e     phase_q;
  logic [`DDR_TG_BEAT_W-1:0]   beats_q;
  ddr_tg_data_pkg::lane_word_t seed_q;
  logic [`DDR_TG_BEAT_W-1:0]   cnt_q;
  logic                        busy;
  logic                        apb_wr;
  logic                        addr_hit;
  logic                        start;
  logic                        wr_fire;
  logic                        rd_fire;
  logic                        last_beat;

  // ************************************************************************
  // APB register access
  // ************************************************************************

  assign busy   = (phase_q != ddr_tg_data_pkg::IDLE);
  assign apb_wr = psel_i && penable_i && pwrite_i;

  // A run needs a calibrated memory, an idle checker and a nonzero length
  assign start = apb_wr && (paddr_i == ddr_tg_reg_pkg::REG_CTRL) && pwdata_i[0] &&
                 init_calib_complete_i && !busy && (beats_q != '0);

  assign clr_o = apb_wr && (paddr_i == ddr_tg_reg_pkg::REG_STATUS) && pwdata_i[2];

  // Run setup is frozen while busy
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beats_q <= '0;
      seed_q  <= '0;
    end else if (apb_wr && !busy) begin
      if (paddr_i == ddr_tg_reg_pkg::REG_BEATS) begin
        beats_q <= pwdata_i[`DDR_TG_BEAT_W-1:0];
      end
      if (paddr_i == ddr_tg_reg_pkg::REG_SEED) begin
        seed_q <= pwdata_i;
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      ddr_tg_reg_pkg::REG_CTRL:      prdata_o = '0;
      ddr_tg_reg_pkg::REG_BEATS:     prdata_o[`DDR_TG_BEAT_W-1:0] = beats_q;
      ddr_tg_reg_pkg::REG_SEED:      prdata_o = seed_q;
      ddr_tg_reg_pkg::REG_STATUS:    prdata_o[2:0] = {status_i.error, status_i.done, busy};
      ddr_tg_reg_pkg::REG_ERR_COUNT: prdata_o[`DDR_TG_BEAT_W-1:0] = status_i.err_count;
      ddr_tg_reg_pkg::REG_LANE_MASK: prdata_o[`DDR_TG_NUM_LANES-1:0] = status_i.lane_mask;
      default:                       addr_hit = 1'b0;
    endcase
  end

  assign pslverr_o = psel_i && penable_i && !addr_hit;

  // ************************************************************************
  // Phase machine and beat counter
  // ************************************************************************

  assign wr_fire   = (phase_q == ddr_tg_data_pkg::WRITE) && app_rdy_i && app_wdf_rdy_i;
  assign rd_fire   = (phase_q == ddr_tg_data_pkg::READ) && app_rdy_i;
  assign last_beat = (cnt_q == beats_q - 1'b1);

  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= ddr_tg_data_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (phase_q)
        ddr_tg_data_pkg::IDLE: begin
          if (start) begin
            phase_q <= ddr_tg_data_pkg::WRITE;
            cnt_q   <= '0;
          end
        end
        ddr_tg_data_pkg::WRITE: begin
          if (wr_fire) begin
            cnt_q   <= last_beat ? '0 : cnt_q + 1'b1;
            phase_q <= last_beat ? ddr_tg_data_pkg::READ : ddr_tg_data_pkg::WRITE;
          end
        end
        ddr_tg_data_pkg::READ: begin
          if (rd_fire) begin
            cnt_q   <= last_beat ? '0 : cnt_q + 1'b1;
            phase_q <= last_beat ? ddr_tg_data_pkg::WAIT_DONE : ddr_tg_data_pkg::READ;
          end
        end
        // Read data may still be in flight
        ddr_tg_data_pkg::WAIT_DONE: begin
          if (status_i.done) begin
            phase_q <= ddr_tg_data_pkg::IDLE;
          end
        end
        default: phase_q <= ddr_tg_data_pkg::IDLE;
      endcase
    end
  end

  // Application port held by the counter until the beat fires
  assign app_en_o       = (phase_q == ddr_tg_data_pkg::WRITE) ||
                          (phase_q == ddr_tg_data_pkg::READ);
  assign app_cmd_o      = (phase_q == ddr_tg_data_pkg::READ) ? 3'd1 : 3'd0;
  assign app_addr_o     = `DDR_TG_APP_AW'({cnt_q, 3'b000});
  assign app_wdf_wren_o = (phase_q == ddr_tg_data_pkg::WRITE);
  assign app_wdf_end_o  = (phase_q == ddr_tg_data_pkg::WRITE);

  for (genvar i = 0; i < `DDR_TG_NUM_LANES; i++) begin : g_wdata
    assign app_wdf_data_o[i*`DDR_TG_LANE_W +: `DDR_TG_LANE_W] = res[i].wr_word;
  end

  // Lane broadcast
  assign ctrl.start    = start;
  assign ctrl.seed     = seed_q;
  assign ctrl.beats    = beats_q;
  assign ctrl.wr_fire  = wr_fire;
  assign ctrl.rd_valid = app_rd_data_valid_i;
  assign ctrl.rd_data  = app_rd_data_i;

  // Command and lane write data must hold under back-pressure
  a_app_hold: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n_i)
    app_en_o && !(wr_fire || rd_fire) |=>
      app_en_o && $stable(app_cmd_o) && $stable(app_addr_o) && $stable(app_wdf_data_o))
    else $error("application command or write data changed before the beat fired");

endmodule

`default_nettype wire

// File: ddr_tg_lane.sv
// DDR4 traffic checker lane with write pattern generator and read data checker
`timescale 1ns/1ns
`default_nettype none
`include "ddr_tg_params.svh"

module ddr_tg_lane #(
  parameter int unsigned LANE = 0
) (
  input  wire          c0_ddr4_clk,
  input  wire          arst_n_i,
  lane_ctrl_if.lane    ctrl,
  lane_result_if.lane  res
);

  // Each lane walks its own odd stride
  localparam ddr_tg_data_pkg::lane_word_t STRIDE = ddr_tg_data_pkg::lane_word_t'(2*LANE + 1);

  ddr_tg_data_pkg::lane_word_t wr_acc_q;
  ddr_tg_data_pkg::lane_word_t rd_acc_q;
  ddr_tg_data_pkg::lane_word_t rd_slice;
  logic                        mismatch_q;
  logic                        mismatch_valid_q;
  logic                        started_q;

  assign rd_slice = ctrl.rd_data[LANE*`DDR_TG_LANE_W +: `DDR_TG_LANE_W];

  // Pattern accumulators, loaded on every start
  always_ff @(posedge c0_ddr4_clk) begin
    if (ctrl.start) begin
      wr_acc_q <= ctrl.seed;
      rd_acc_q <= ctrl.seed;
    end else begin
      if (ctrl.wr_fire) begin
        wr_acc_q <= wr_acc_q + STRIDE;
      end
      if (ctrl.rd_valid) begin
        rd_acc_q <= rd_acc_q + STRIDE;
      end
    end
  end

  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mismatch_q       <= 1'b0;
      mismatch_valid_q <= 1'b0;
      started_q        <= 1'b0;
    end else begin
      mismatch_q       <= ctrl.rd_valid && (rd_slice != rd_acc_q);
      mismatch_valid_q <= ctrl.rd_valid;
      if (ctrl.start) begin
        started_q <= 1'b1;
      end
    end
  end

  assign res.wr_word        = wr_acc_q;
  assign res.mismatch       = mismatch_q;
  assign res.mismatch_valid = mismatch_valid_q;

  // No read data may arrive before the first run
  a_rd_after_start: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n_i)
    ctrl.rd_valid |-> started_q)
    else $error("lane %0d saw read data before any start", LANE);

endmodule

`default_nettype wire

// File: ddr_tg_collector.sv
// DDR4 traffic checker collector for lane mismatches, error count and run completion
`timescale 1ns/1ns
`default_nettype none
`include "ddr_tg_params.svh"

module ddr_tg_collector (
  input  wire                           c0_ddr4_clk,
  input  wire                           arst_n_i,
  input  wire                           clr_i,
  output ddr_tg_reg_pkg::status_t       status_o,
  output logic                          data_compare_error_o,
  lane_ctrl_if.monitor                  ctrl,
  lane_result_if.collector              res [`DDR_TG_NUM_LANES]
);

  logic [`DDR_TG_NUM_LANES-1:0] hit;
  logic                         beat_valid;
  logic [`DDR_TG_NUM_LANES-1:0] lane_mask_q;
  logic [`DDR_TG_BEAT_W-1:0]    err_count_q;
  logic                         error_q;
  logic [`DDR_TG_BEAT_W-1:0]    beats_q;
  logic [`DDR_TG_BEAT_W-1:0]    rd_run_q;
  logic [`DDR_TG_BEAT_W-1:0]    rd_total_q;
  logic                         done_q;

  for (genvar i = 0; i < `DDR_TG_NUM_LANES; i++) begin : g_hit
    assign hit[i] = res[i].mismatch_valid && res[i].mismatch;
  end

  // All lanes see the same read beat, lane 0 stands for the beat
  assign beat_valid = res[0].mismatch_valid;

  // ************************************************************************
  // Error tracking, sticky until cleared
  // ************************************************************************

  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_mask_q <= '0;
      err_count_q <= '0;
      error_q     <= 1'b0;
      rd_total_q  <= '0;
    end else if (clr_i) begin
      lane_mask_q <= '0;
      err_count_q <= '0;
      error_q     <= 1'b0;
      rd_total_q  <= '0;
    end else begin
      lane_mask_q <= lane_mask_q | hit;
      if (|hit) begin
        error_q <= 1'b1;
        if (err_count_q != '1) begin
          err_count_q <= err_count_q + 1'b1;
        end
      end
      if (beat_valid && rd_total_q != '1) begin
        rd_total_q <= rd_total_q + 1'b1;
      end
    end
  end

  // ************************************************************************
  // Run completion
  // ************************************************************************

  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beats_q  <= '0;
      rd_run_q <= '0;
      done_q   <= 1'b0;
    end else if (ctrl.start) begin
      beats_q  <= ctrl.beats;
      rd_run_q <= '0;
      done_q   <= 1'b0;
    end else if (beat_valid && !done_q) begin
      rd_run_q <= rd_run_q + 1'b1;
      if (rd_run_q == beats_q - 1'b1) begin
        done_q <= 1'b1;
      end
    end
  end

  assign status_o.done      = done_q;
  assign status_o.error     = error_q;
  assign status_o.err_count = err_count_q;
  assign status_o.lane_mask = lane_mask_q;
  assign data_compare_error_o = error_q;

  a_err_le_reads: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n_i)
    err_count_q <= rd_total_q)
    else $error("error count %0d exceeds read beats %0d", err_count_q, rd_total_q);

endmodule

`default_nettype wire

// File: ddr_tg_top.sv
// DDR4 application-side traffic checker top level with APB control
`timescale 1ns/1ns
`default_nettype none
`include "ddr_tg_params.svh"

module ddr_tg_top (
  input  wire                        c0_ddr4_clk,
  input  wire                        arst_n_i,
  // APB slave
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire [`DDR_TG_APB_AW-1:0]   paddr_i,
  input  wire [31:0]                 pwdata_i,
  output wire [31:0]                 prdata_o,
  output wire                        pready_o,
  output wire                        pslverr_o,
  // Memory controller application port
  input  wire                        c0_init_calib_complete_i,
  output wire                        app_en_o,
  output wire [2:0]                  app_cmd_o,
  output wire [`DDR_TG_APP_AW-1:0]   app_addr_o,
  output wire [`DDR_TG_DATA_W-1:0]   app_wdf_data_o,
  output wire                        app_wdf_wren_o,
  output wire                        app_wdf_end_o,
  input  wire                        app_rdy_i,
  input  wire                        app_wdf_rdy_i,
  input  wire [`DDR_TG_DATA_W-1:0]   app_rd_data_i,
  input  wire                        app_rd_data_valid_i,
  // Sticky compare failure
  output wire                        data_compare_error_o
);

  ddr_tg_reg_pkg::status_t status;
  logic                    clr;

  lane_ctrl_if   ctrl_if ();
  lane_result_if res_if [`DDR_TG_NUM_LANES] ();

  // Registers always answer in the access phase
  assign pready_o = 1'b1;

  ddr_tg_sequencer i_sequencer (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .arst_n_i              (arst_n_i),
    .psel_i                (psel_i),
    .penable_i             (penable_i),
    .pwrite_i              (pwrite_i),
    .paddr_i               (paddr_i),
    .pwdata_i              (pwdata_i),
    .prdata_o              (prdata_o),
    .pslverr_o             (pslverr_o),
    .init_calib_complete_i (c0_init_calib_complete_i),
    .app_rdy_i             (app_rdy_i),
    .app_wdf_rdy_i         (app_wdf_rdy_i),
    .app_rd_data_i         (app_rd_data_i),
    .app_rd_data_valid_i   (app_rd_data_valid_i),
    .app_en_o              (app_en_o),
    .app_cmd_o             (app_cmd_o),
    .app_addr_o            (app_addr_o),
    .app_wdf_data_o        (app_wdf_data_o),
    .app_wdf_wren_o        (app_wdf_wren_o),
    .app_wdf_end_o         (app_wdf_end_o),
    .status_i              (status),
    .clr_o                 (clr),
    .ctrl                  (ctrl_if),
    .res                   (res_if)
  );

  // ************************************************************************
  // Pattern lanes
  // ************************************************************************
  for (genvar g = 0; g < `DDR_TG_NUM_LANES; g++) begin : g_lane
    ddr_tg_lane #(
      .LANE (g)
    ) i_lane (
      .c0_ddr4_clk (c0_ddr4_clk),
      .arst_n_i    (arst_n_i),
      .ctrl        (ctrl_if),
      .res         (res_if[g])
    );
  end

  ddr_tg_collector i_collector (
    .c0_ddr4_clk          (c0_ddr4_clk),
    .arst_n_i             (arst_n_i),
    .clr_i                (clr),
    .status_o             (status),
    .data_compare_error_o (data_compare_error_o),
    .ctrl                 (ctrl_if),
    .res                  (res_if)
  );

endmodule

`default_nettype wire

// File: tb_ddr_tg.sv
// DDR4 traffic checker testbench with APB driver, echoing memory model and pattern assertions
`timescale 1ns/1ns
`default_nettype none
`include "ddr_tg_params.svh"

module tb_ddr_tg;

  // Beats programmed over all runs including the gated start
  localparam int TOTAL_BEATS     = 8 + 24 + 40 + 16;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_BEATS + 2000;

  logic                         c0_ddr4_clk = 1'b0;
  logic                         arst_n = 1'b0;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [`DDR_TG_APB_AW-1:0]    paddr;
  logic [31:0]                  pwdata;
  logic [31:0]                  prdata;
  logic                         pready;
  logic                         pslverr;
  logic                         calib;
  logic                         app_en;
  logic [2:0]                   app_cmd;
  logic [`DDR_TG_APP_AW-1:0]    app_addr;
  logic [`DDR_TG_DATA_W-1:0]    app_wdf_data;
  logic                         app_wdf_wren;
  logic                         app_wdf_end;
  logic                         app_rdy = 1'b0;
  logic                         app_wdf_rdy = 1'b0;
  logic [`DDR_TG_DATA_W-1:0]    app_rd_data = '0;
  logic                         app_rd_data_valid = 1'b0;
  logic                         data_compare_error;

  // Run bookkeeping
  logic [31:0]                  cur_seed = '0;
  int                           run_beats = 0;
  int                           wr_cnt = 0;
  int                           rd_cnt = 0;
  int                           wr_base = 0;
  int                           rd_base = 0;
  logic                         back_pressure = 1'b0;
  logic                         inject_on = 1'b0;
  logic [7:0]                   inj_beat = '0;
  int                           inj_bit = 0;
  logic                         err_expected = 1'b0;

  // Memory model state
  logic [31:0]                  lfsr = 32'h0b02_b4c8;
  int                           cyc = 0;
  logic [`DDR_TG_DATA_W-1:0]    mem [0:255];
  logic [`DDR_TG_DATA_W-1:0]    rd_q [$];
  int                           due_q [$];

  logic                         wr_fire_w;
  logic                         rd_fire_w;

  always #10 c0_ddr4_clk = ~c0_ddr4_clk;

  ddr_tg_top i_ddr_tg_top (
    .c0_ddr4_clk              (c0_ddr4_clk),
    .arst_n_i                 (arst_n),
    .psel_i                   (psel),
    .penable_i                (penable),
    .pwrite_i                 (pwrite),
    .paddr_i                  (paddr),
    .pwdata_i                 (pwdata),
    .prdata_o                 (prdata),
    .pready_o                 (pready),
    .pslverr_o                (pslverr),
    .c0_init_calib_complete_i (calib),
    .app_en_o                 (app_en),
    .app_cmd_o                (app_cmd),
    .app_addr_o               (app_addr),
    .app_wdf_data_o           (app_wdf_data),
    .app_wdf_wren_o           (app_wdf_wren),
    .app_wdf_end_o            (app_wdf_end),
    .app_rdy_i                (app_rdy),
    .app_wdf_rdy_i            (app_wdf_rdy),
    .app_rd_data_i            (app_rd_data),
    .app_rd_data_valid_i      (app_rd_data_valid),
    .data_compare_error_o     (data_compare_error)
  );

  // ************************************************************************
  // Failure reporting and helpers
  // ************************************************************************

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                 input logic [127:0] got_v);
    $display("error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, got_v);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("at %0t ns: %s", $time, what);
    abort_run();
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[6:0], fb};
    end
    return v;
  endfunction

  // Lane L of beat k carries seed + k * (2L + 1)
  function automatic logic [`DDR_TG_DATA_W-1:0] exp_word(input int k);
    logic [`DDR_TG_DATA_W-1:0] w;
    for (int l = 0; l < `DDR_TG_NUM_LANES; l++) begin
      w[l*`DDR_TG_LANE_W +: `DDR_TG_LANE_W] = cur_seed + 32'(k * (2*l + 1));
    end
    return w;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge c0_ddr4_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge c0_ddr4_clk);
    penable = 1'b1;
    @(negedge c0_ddr4_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge c0_ddr4_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge c0_ddr4_clk);
    penable = 1'b1;
    @(posedge c0_ddr4_clk);
    data = prdata;
    err  = pslverr;
    @(negedge c0_ddr4_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp_v, input string name);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    assert (!err) else report_failure({"pslverr while reading ", name});
    assert (data == exp_v) else report_mismatch(name, 128'(exp_v), 128'(data));
  endtask

  // Program and start a run, then poll STATUS until done
  task automatic run_traffic(input logic [31:0] seed, input int beats);
    logic [31:0] st;
    logic        err;
    cur_seed  = seed;
    run_beats = beats;
    wr_base   = wr_cnt;
    rd_base   = rd_cnt;
    apb_write(ddr_tg_reg_pkg::REG_SEED, seed);
    apb_write(ddr_tg_reg_pkg::REG_BEATS, 32'(beats));
    apb_write(ddr_tg_reg_pkg::REG_CTRL, 32'h1);
    st = '0;
    while (!st[1]) begin
      apb_read(ddr_tg_reg_pkg::REG_STATUS, st, err);
    end
    assert (wr_cnt - wr_base == beats)
      else report_mismatch("write beats fired", 128'(beats), 128'(wr_cnt - wr_base));
    assert (rd_cnt - rd_base == beats)
      else report_mismatch("read beats fired", 128'(beats), 128'(rd_cnt - rd_base));
    assert (rd_q.size() == 0) else report_failure("read data left over after done");
  endtask

  // ************************************************************************
  // Memory echo model driven on the falling edge
  // ************************************************************************

  assign wr_fire_w = app_en && app_rdy && app_wdf_rdy && (app_cmd == 3'd0);
  assign rd_fire_w = app_en && app_rdy && (app_cmd == 3'd1);

  always @(negedge c0_ddr4_clk) begin : memory_echo
    logic [7:0]                r;
    logic [`DDR_TG_DATA_W-1:0] word;
    cyc = cyc + 1;
    if (back_pressure) begin
      r           = take_bits(2);
      app_rdy     = |r[1:0];
      r           = take_bits(2);
      app_wdf_rdy = |r[1:0];
    end else begin
      app_rdy     = 1'b1;
      app_wdf_rdy = 1'b1;
    end
    // Beats that fire on the coming rising edge
    if (app_en && app_rdy && app_wdf_rdy && app_cmd == 3'd0) begin
      mem[app_addr[10:3]] = app_wdf_data;
    end
    if (app_en && app_rdy && app_cmd == 3'd1) begin
      word = mem[app_addr[10:3]];
      if (inject_on && app_addr[10:3] == inj_beat) begin
        word[inj_bit] = ~word[inj_bit];
      end
      r = take_bits(2);
      rd_q.push_back(word);
      due_q.push_back(cyc + 1 + int'(r[1:0]));
    end
    if (rd_q.size() != 0 && due_q[0] <= cyc) begin
      app_rd_data_valid = 1'b1;
      app_rd_data       = rd_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      app_rd_data_valid = 1'b0;
      app_rd_data       = '0;
    end
  end

  always @(posedge c0_ddr4_clk) begin
    if (wr_fire_w) begin
      wr_cnt <= wr_cnt + 1;
    end
    if (rd_fire_w) begin
      rd_cnt <= rd_cnt + 1;
    end
  end

  // ************************************************************************
  // Assertions
  // ************************************************************************

  a_pready: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    psel && penable |-> pready)
    else report_failure("pready low in the APB access phase");

  a_wr_data: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    wr_fire_w |-> app_wdf_data == exp_word(wr_cnt - wr_base))
    else report_mismatch("app_wdf_data_o", exp_word($sampled(wr_cnt) - wr_base),
                         $sampled(app_wdf_data));

  a_wr_addr: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    wr_fire_w |-> app_addr == `DDR_TG_APP_AW'((wr_cnt - wr_base) * 8))
    else report_mismatch("app_addr_o", 128'(($sampled(wr_cnt) - wr_base) * 8),
                         128'($sampled(app_addr)));

  a_rd_addr: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    rd_fire_w |-> app_addr == `DDR_TG_APP_AW'((rd_cnt - rd_base) * 8))
    else report_mismatch("app_addr_o", 128'(($sampled(rd_cnt) - rd_base) * 8),
                         128'($sampled(app_addr)));

  a_wr_limit: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    wr_fire_w |-> wr_cnt - wr_base < run_beats)
    else report_failure("more write beats fired than programmed in BEATS");

  a_rd_limit: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    rd_fire_w |-> rd_cnt - rd_base < run_beats)
    else report_failure("more read beats fired than programmed in BEATS");

  a_app_hold: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    app_en && !(wr_fire_w || rd_fire_w) |=>
      app_en && $stable(app_cmd) && $stable(app_addr) && $stable(app_wdf_data))
    else report_failure("application command changed while waiting for ready");

  a_wdf_enables: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    (app_wdf_wren == (app_en && app_cmd == 3'd0)) && (app_wdf_end == app_wdf_wren))
    else report_failure("write data enables do not follow app_en in the write phase");

  a_calib_gate: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    !calib |-> !app_en)
    else report_failure("app_en raised before calibration completed");

  a_no_error: assert property (@(posedge c0_ddr4_clk) disable iff (!arst_n)
    !err_expected |-> !data_compare_error)
    else report_failure("data_compare_error raised on clean traffic");

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  initial begin : stimulus
    logic [31:0] data;
    logic        err;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    calib   = 1'b0;
    repeat (3) @(negedge c0_ddr4_clk);
    arst_n = 1'b1;
    assert (!app_en && !app_wdf_wren && !data_compare_error)
      else report_failure("application port or error flag not low after reset");
    check_reg(ddr_tg_reg_pkg::REG_STATUS, 32'h0, "STATUS after reset");

    // Register access
    apb_write(ddr_tg_reg_pkg::REG_SEED, 32'hdead_0123);
    check_reg(ddr_tg_reg_pkg::REG_SEED, 32'hdead_0123, "SEED");
    apb_write(ddr_tg_reg_pkg::REG_BEATS, 32'h0000_0a5c);
    check_reg(ddr_tg_reg_pkg::REG_BEATS, 32'h0000_0a5c, "BEATS");
    apb_read(8'h18, data, err);
    assert (err) else report_failure("no pslverr for unmapped offset 0x18");

    // Start while the memory is not calibrated
    apb_write(ddr_tg_reg_pkg::REG_BEATS, 32'd8);
    apb_write(ddr_tg_reg_pkg::REG_CTRL, 32'h1);
    repeat (20) @(negedge c0_ddr4_clk);
    check_reg(ddr_tg_reg_pkg::REG_STATUS, 32'h0, "STATUS after gated start");
    calib = 1'b1;

    // Clean run followed by one with random ready
    run_traffic(32'h1357_9bdf, 24);
    check_reg(ddr_tg_reg_pkg::REG_ERR_COUNT, 32'h0, "ERR_COUNT after clean run");
    back_pressure = 1'b1;
    run_traffic(32'hfedc_ba98, 40);
    check_reg(ddr_tg_reg_pkg::REG_ERR_COUNT, 32'h0, "ERR_COUNT after back-pressure run");
    check_reg(ddr_tg_reg_pkg::REG_LANE_MASK, 32'h0, "LANE_MASK after back-pressure run");

    // One flipped bit in lane 2 of beat 5
    inj_beat     = 8'd5;
    inj_bit      = 2 * `DDR_TG_LANE_W + 9;
    inject_on    = 1'b1;
    err_expected = 1'b1;
    run_traffic(32'h0f0f_1234, 16);
    assert (data_compare_error)
      else report_mismatch("data_compare_error_o", 128'(1), 128'(data_compare_error));
    check_reg(ddr_tg_reg_pkg::REG_ERR_COUNT, 32'h1, "ERR_COUNT after injected error");
    check_reg(ddr_tg_reg_pkg::REG_LANE_MASK, 32'h4, "LANE_MASK after injected error");
    inject_on = 1'b0;
    apb_write(ddr_tg_reg_pkg::REG_STATUS, 32'h4);
    err_expected = 1'b0;
    check_reg(ddr_tg_reg_pkg::REG_ERR_COUNT, 32'h0, "ERR_COUNT after clear");
    check_reg(ddr_tg_reg_pkg::REG_LANE_MASK, 32'h0, "LANE_MASK after clear");
    check_reg(ddr_tg_reg_pkg::REG_STATUS, 32'h2, "STATUS after clear");

    $display("TEST OK");
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge c0_ddr4_clk);
    report_failure("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
ddr_tg_reg_pkg.sv
ddr_tg_data_pkg.sv
ddr_tg_if.sv
ddr_tg_sequencer.sv
ddr_tg_lane.sv
ddr_tg_collector.sv
ddr_tg_top.sv
tb_ddr_tg.sv

// File: Makefile
TOP := tb_ddr_tg

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
